//--- include/ooo_core_cfg.svh
`ifndef OOO_CORE_CFG_SVH
`define OOO_CORE_CFG_SVH

// general-purpose register file
`define GPR_COUNT 16
`define GPR_IDX_SIZE 4
`define GPR_SIZE 32

// reorder buffer, the tag must address every entry
`define ROB_DEPTH 8
`define ROB_TAG_SIZE 3

// number of register stages in the multiply pipeline
`define MUL_LATENCY 3

`endif

//--- source/ooo_core_pkg.sv
`default_nettype none

`include "ooo_core_cfg.svh"

package ooo_core_pkg;

    typedef logic [`GPR_IDX_SIZE-1:0] gpr_idx_t;
    typedef logic [`GPR_SIZE-1:0] gpr_value_t;
    typedef logic [`ROB_TAG_SIZE-1:0] rob_tag_t;
    typedef logic [`ROB_TAG_SIZE:0] rob_count_t; // counts 0 up to ROB_DEPTH
    typedef logic [15:0] imm_t;
    typedef logic [2:0] opcode_t;

    localparam opcode_t OP_ADD = 3'd0;
    localparam opcode_t OP_SUB = 3'd1;
    localparam opcode_t OP_AND = 3'd2;
    localparam opcode_t OP_XOR = 3'd3;
    localparam opcode_t OP_ADDI = 3'd4; // src1 plus sign-extended imm
    localparam opcode_t OP_MUL = 3'd5;

    typedef struct packed {
        opcode_t opcode;
        gpr_idx_t dest;
        gpr_idx_t src1;
        gpr_idx_t src2;
        imm_t imm;
    } instr_t;

    typedef struct packed {
        opcode_t opcode;
        rob_tag_t tag;
        gpr_value_t op_a;
        gpr_value_t op_b; // already holds the extended immediate for ADDI
    } issue_t;

    typedef struct packed {
        rob_tag_t tag;
        gpr_value_t value;
    } result_t;

    typedef struct packed {
        gpr_idx_t dest;
        gpr_value_t value;
    } commit_t;

endpackage

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_core_cfg.svh"

module regfile (
    input logic in_clk,
    input logic in_rst,
    input ooo_core_pkg::gpr_idx_t rd_idx_a,
    input ooo_core_pkg::gpr_idx_t rd_idx_b,
    output ooo_core_pkg::gpr_value_t rd_value_a,
    output ooo_core_pkg::gpr_value_t rd_value_b,
    input logic wr_en,
    input ooo_core_pkg::gpr_idx_t wr_idx,
    input ooo_core_pkg::gpr_value_t wr_value
);

    import ooo_core_pkg::*;

    gpr_value_t regs [`GPR_COUNT];
    logic hit_a;
    logic hit_b;

    // architectural state only changes when the reorder buffer commits
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_value;
        end
    end

    assign hit_a = wr_en && (wr_idx == rd_idx_a); // consumer released by this commit
    assign hit_b = wr_en && (wr_idx == rd_idx_b);

    always_comb begin
        if (hit_a) begin
            rd_value_a = wr_value; // write-first so the fresh value is seen now
        end else begin
            rd_value_a = regs[rd_idx_a];
        end
    end

    always_comb begin
        if (hit_b) begin
            rd_value_b = wr_value;
        end else begin
            rd_value_b = regs[rd_idx_b];
        end
    end

endmodule

`default_nettype wire

//--- source/dispatch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_core_cfg.svh"

module dispatch_stage (
    input logic in_clk,
    input logic in_rst,
    input ooo_core_pkg::instr_t instr,
    input logic instr_valid,
    output logic instr_ready,
    output ooo_core_pkg::gpr_idx_t rd_idx_a,
    output ooo_core_pkg::gpr_idx_t rd_idx_b,
    input ooo_core_pkg::gpr_value_t rd_value_a,
    input ooo_core_pkg::gpr_value_t rd_value_b,
    output logic alloc_valid,
    output ooo_core_pkg::gpr_idx_t alloc_dest,
    input logic alloc_ready,
    input ooo_core_pkg::rob_tag_t alloc_tag,
    input logic commit_fire,
    input ooo_core_pkg::gpr_idx_t commit_dest,
    output ooo_core_pkg::issue_t issue,
    output logic issue_valid
);

    import ooo_core_pkg::*;

    rob_count_t inflight [`GPR_COUNT]; // uncommitted writes per register
    rob_count_t cnt_a;
    rob_count_t cnt_b;
    logic rel_a;
    logic rel_b;
    logic busy_a;
    logic busy_b;
    logic accept;
    gpr_value_t imm_ext;

    assign rd_idx_a = instr.src1;
    assign rd_idx_b = instr.src2;

    assign cnt_a = inflight[instr.src1];
    assign cnt_b = inflight[instr.src2];

    // the last pending write commits this cycle, so the bypass covers the read
    assign rel_a = commit_fire && (commit_dest == instr.src1) && (cnt_a == rob_count_t'(1));
    assign rel_b = commit_fire && (commit_dest == instr.src2) && (cnt_b == rob_count_t'(1));

    assign busy_a = (cnt_a != '0) && !rel_a;
    assign busy_b = (cnt_b != '0) && !rel_b && (instr.opcode != OP_ADDI); // ADDI has no src2

    assign instr_ready = alloc_ready && !busy_a && !busy_b && !in_rst;
    assign accept = instr_valid && instr_ready;

    assign alloc_valid = accept;
    assign alloc_dest = instr.dest;

    assign imm_ext = {{(`GPR_SIZE-16){instr.imm[15]}}, instr.imm};

    // scoreboard, an accept and a commit to the same register cancel out
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                inflight[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                if (accept && (instr.dest == gpr_idx_t'(i)) &&
                    !(commit_fire && (commit_dest == gpr_idx_t'(i)))) begin
                    inflight[i] <= inflight[i] + 1'b1;
                end else if (commit_fire && (commit_dest == gpr_idx_t'(i)) &&
                             !(accept && (instr.dest == gpr_idx_t'(i)))) begin
                    inflight[i] <= inflight[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept; // execute never back-pressures
        end
    end

    always_ff @(posedge in_clk) begin
        if (accept) begin
            issue.opcode <= instr.opcode;
            issue.tag <= alloc_tag;
            issue.op_a <= rd_value_a;
            issue.op_b <= (instr.opcode == OP_ADDI) ? imm_ext : rd_value_b;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_core_cfg.svh"

module execute_stage (
    input logic in_clk,
    input logic in_rst,
    input ooo_core_pkg::issue_t issue,
    input logic issue_valid,
    output ooo_core_pkg::result_t alu_result,
    output logic alu_valid,
    output ooo_core_pkg::result_t mul_result,
    output logic mul_valid
);

    import ooo_core_pkg::*;

    localparam int MUL_STAGES = `MUL_LATENCY;

    logic is_mul;
    gpr_value_t mul_low;
    logic mul_valid_q [MUL_STAGES];
    result_t mul_pipe [MUL_STAGES];

    assign is_mul = (issue.opcode == OP_MUL);
    assign mul_low = issue.op_a * issue.op_b; // only the low word of the product is kept

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid && !is_mul; // unknown opcodes complete here with zero
        end
    end

    always_ff @(posedge in_clk) begin
        if (issue_valid) begin
            alu_result.tag <= issue.tag;
            case (issue.opcode)
                OP_ADD, OP_ADDI: alu_result.value <= issue.op_a + issue.op_b;
                OP_SUB: alu_result.value <= issue.op_a - issue.op_b;
                OP_AND: alu_result.value <= issue.op_a & issue.op_b;
                OP_XOR: alu_result.value <= issue.op_a ^ issue.op_b;
                default: alu_result.value <= '0;
            endcase
        end
    end

    // multiply pipeline takes a new operation every cycle
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                mul_valid_q[i] <= 1'b0;
            end
        end else begin
            mul_valid_q[0] <= issue_valid && is_mul;
            for (int i = 1; i < MUL_STAGES; i++) begin
                mul_valid_q[i] <= mul_valid_q[i-1];
            end
        end
    end

    always_ff @(posedge in_clk) begin
        mul_pipe[0].tag <= issue.tag;
        mul_pipe[0].value <= mul_low;
        for (int i = 1; i < MUL_STAGES; i++) begin
            mul_pipe[i] <= mul_pipe[i-1];
        end
    end

    assign mul_result = mul_pipe[MUL_STAGES-1];
    assign mul_valid = mul_valid_q[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_core_cfg.svh"

module reorder_buffer (
    input logic in_clk,
    input logic in_rst,
    input logic alloc_valid,
    input ooo_core_pkg::gpr_idx_t alloc_dest,
    output logic alloc_ready,
    output ooo_core_pkg::rob_tag_t alloc_tag,
    input ooo_core_pkg::result_t alu_result,
    input logic alu_valid,
    input ooo_core_pkg::result_t mul_result,
    input logic mul_valid,
    output ooo_core_pkg::commit_t commit,
    output logic commit_valid,
    input logic commit_ready,
    output logic commit_fire,
    output logic wr_en,
    output ooo_core_pkg::gpr_idx_t wr_idx,
    output ooo_core_pkg::gpr_value_t wr_value
);

    import ooo_core_pkg::*;

    localparam int DEPTH = `ROB_DEPTH;

    gpr_idx_t dest_mem [DEPTH];
    gpr_value_t value_mem [DEPTH];
    logic done [DEPTH];
    rob_tag_t head;
    rob_tag_t tail;
    rob_count_t count;
    logic alloc_fire;

    function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
        if (ptr == rob_tag_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign alloc_ready = (count != rob_count_t'(DEPTH));
    assign alloc_tag = tail; // dispatch gets the slot in the same cycle
    assign alloc_fire = alloc_valid && alloc_ready;

    assign commit_valid = (count != '0) && done[head]; // results leave in program order
    assign commit.dest = dest_mem[head];
    assign commit.value = value_mem[head];
    assign commit_fire = commit_valid && commit_ready;

    assign wr_en = commit_fire;
    assign wr_idx = dest_mem[head];
    assign wr_value = value_mem[head];

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc_fire) begin
                tail <= next_ptr(tail);
            end
            if (commit_fire) begin
                head <= next_ptr(head);
            end
            if (alloc_fire && !commit_fire) begin
                count <= count + 1'b1;
            end else if (commit_fire && !alloc_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // the tail slot is free, so it never collides with a completing tag
    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                done[tail] <= 1'b0;
            end
            if (alu_valid) begin
                done[alu_result.tag] <= 1'b1;
            end
            if (mul_valid) begin
                done[mul_result.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (alloc_fire) begin
            dest_mem[tail] <= alloc_dest;
        end
        if (alu_valid) begin
            value_mem[alu_result.tag] <= alu_result.value;
        end
        if (mul_valid) begin
            value_mem[mul_result.tag] <= mul_result.value;
        end
    end

endmodule

`default_nettype wire

//--- source/ooo_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top (
    input logic in_clk,
    input logic in_rst,
    input ooo_core_pkg::instr_t instr,
    input logic instr_valid,
    output logic instr_ready,
    output ooo_core_pkg::commit_t commit,
    output logic commit_valid,
    input logic commit_ready
);

    import ooo_core_pkg::*;

    gpr_idx_t rd_idx_a;
    gpr_idx_t rd_idx_b;
    gpr_value_t rd_value_a;
    gpr_value_t rd_value_b;
    logic wr_en;
    gpr_idx_t wr_idx;
    gpr_value_t wr_value;
    logic alloc_valid;
    gpr_idx_t alloc_dest;
    logic alloc_ready;
    rob_tag_t alloc_tag;
    logic commit_fire;
    issue_t issue;
    logic issue_valid;
    result_t alu_result;
    logic alu_valid;
    result_t mul_result;
    logic mul_valid;

    dispatch_stage u_dispatch (
        .in_clk(in_clk), .in_rst(in_rst),
        .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_value_a(rd_value_a), .rd_value_b(rd_value_b),
        .alloc_valid(alloc_valid), .alloc_dest(alloc_dest),
        .alloc_ready(alloc_ready), .alloc_tag(alloc_tag),
        .commit_fire(commit_fire), .commit_dest(commit.dest),
        .issue(issue), .issue_valid(issue_valid)
    );

    regfile u_regfile (
        .in_clk(in_clk), .in_rst(in_rst),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_value_a(rd_value_a), .rd_value_b(rd_value_b),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_value(wr_value)
    );

    execute_stage u_execute (
        .in_clk(in_clk), .in_rst(in_rst),
        .issue(issue), .issue_valid(issue_valid),
        .alu_result(alu_result), .alu_valid(alu_valid),
        .mul_result(mul_result), .mul_valid(mul_valid)
    );

    reorder_buffer u_rob (
        .in_clk(in_clk), .in_rst(in_rst),
        .alloc_valid(alloc_valid), .alloc_dest(alloc_dest),
        .alloc_ready(alloc_ready), .alloc_tag(alloc_tag),
        .alu_result(alu_result), .alu_valid(alu_valid),
        .mul_result(mul_result), .mul_valid(mul_valid),
        .commit(commit), .commit_valid(commit_valid), .commit_ready(commit_ready),
        .commit_fire(commit_fire),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_value(wr_value)
    );

endmodule

`default_nettype wire

//--- tb/tb_ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "ooo_core_cfg.svh"

module tb_ooo_core;

    import ooo_core_pkg::*;

    localparam int TIMEOUT = 1000;

    logic in_clk;
    logic in_rst;
    instr_t instr;
    logic instr_valid;
    logic instr_ready;
    commit_t commit;
    logic commit_valid;
    logic commit_ready;

    gpr_value_t model_regs [`GPR_COUNT]; // register state in program order
    commit_t expect_q [$];
    logic stall_bits [1024];
    logic random_stall;
    int cycle_idx;
    int error_count;
    int accept_count;
    int commit_count;
    string test_name;

    ooo_core_top UUT (
        .in_clk(in_clk), .in_rst(in_rst),
        .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .commit(commit), .commit_valid(commit_valid), .commit_ready(commit_ready)
    );

    always #5 in_clk = ~in_clk;

    function automatic gpr_value_t ref_execute(input instr_t ins);
        gpr_value_t a;
        gpr_value_t b;
        logic [63:0] product;
        a = model_regs[ins.src1];
        b = model_regs[ins.src2];
        product = {32'b0, a} * {32'b0, b};
        case (ins.opcode)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            OP_ADDI: return a + {{16{ins.imm[15]}}, ins.imm};
            OP_MUL: return product[31:0]; // low word only
            default: return '0;
        endcase
    endfunction

    function automatic instr_t make_instr(input opcode_t op, input int dest, input int src1,
                                          input int src2, input int imm);
        instr_t ins;
        ins.opcode = op;
        ins.dest = gpr_idx_t'(dest);
        ins.src1 = gpr_idx_t'(src1);
        ins.src2 = gpr_idx_t'(src2);
        ins.imm = imm_t'(imm);
        return ins;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout in %s: %s never completed", test_name, what);
        $display("errors: %0d, accepted: %0d, committed: %0d",
                 error_count + 1, accept_count, commit_count);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic send_instr(input instr_t ins);
        int waited;
        waited = 0;
        instr <= ins;
        instr_valid <= 1'b1;
        @(posedge in_clk);
        while (!instr_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("instr_valid/instr_ready");
            end
            @(posedge in_clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        instr_valid <= 1'b0;
        @(negedge in_clk);
        while (expect_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("commit_valid/commit_ready");
            end
            @(negedge in_clk);
        end
        check_value("commit_valid after drain", 0, 32'(commit_valid));
        @(posedge in_clk);
    endtask

    // commit back-pressure follows a pattern drawn before the run starts
    always @(posedge in_clk) begin
        cycle_idx <= cycle_idx + 1;
        if (random_stall) begin
            commit_ready <= stall_bits[cycle_idx % 1024];
        end else begin
            commit_ready <= 1'b1;
        end
    end

    always @(posedge in_clk) begin : track
        commit_t expected;
        if (in_rst) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                model_regs[i] = '0;
            end
            expect_q.delete();
        end else begin
            if (commit_valid && commit_ready) begin
                commit_count++;
                if (expect_q.size() == 0) begin
                    $display("commit of r%0d arrived with no instruction outstanding",
                             commit.dest);
                    error_count++;
                end else begin
                    expected = expect_q.pop_front(); // oldest first
                    check_value("dest", 32'(expected.dest), 32'(commit.dest));
                    check_value("value", expected.value, commit.value);
                end
            end
            if (instr_valid && instr_ready) begin
                accept_count++;
                expected.dest = instr.dest;
                expected.value = ref_execute(instr);
                model_regs[instr.dest] = expected.value;
                expect_q.push_back(expected);
            end
        end
    end

    initial begin
        opcode_t op;
        int dest_reg;
        int src_a;
        int src_b;
        int imm_val;
        int prev;
        void'($urandom(2));
        for (int i = 0; i < 1024; i++) begin
            stall_bits[i] = ($urandom_range(0, 3) != 0);
        end
        in_clk = 1'b0;
        in_rst = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        commit_ready = 1'b1;
        random_stall = 1'b0;
        cycle_idx = 0;
        error_count = 0;
        accept_count = 0;
        commit_count = 0;

        test_name = "reset";
        repeat (3) @(posedge in_clk);
        @(negedge in_clk);
        check_value("instr_ready", 0, 32'(instr_ready));
        check_value("commit_valid", 0, 32'(commit_valid));
        @(posedge in_clk);
        in_rst <= 1'b0;

        test_name = "reset_zero";
        for (int i = 0; i < 4; i++) begin
            send_instr(make_instr(OP_ADD, 1 + i, 8 + i, 12 + i, 0));
        end
        wait_drain();

        test_name = "alu_ops";
        for (int round = 0; round < 4; round++) begin
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(OP_ADDI, 1, 0, 0, imm_val));
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(OP_ADDI, 2, 0, 0, imm_val));
            send_instr(make_instr(OP_ADD, 3, 1, 2, 0));
            send_instr(make_instr(OP_SUB, 4, 1, 2, 0));
            send_instr(make_instr(OP_AND, 5, 1, 2, 0));
            send_instr(make_instr(OP_XOR, 6, 1, 2, 0));
        end
        wait_drain();

        // every source is the previous destination, so each one waits for a commit
        test_name = "dependent_chain";
        imm_val = $urandom_range(1, 65535);
        send_instr(make_instr(OP_ADDI, 7, 0, 0, imm_val));
        prev = 7;
        for (int k = 0; k < 12; k++) begin
            op = opcode_t'($urandom_range(0, 5));
            imm_val = $urandom_range(0, 65535);
            dest_reg = 8 + (k % 6);
            send_instr(make_instr(op, dest_reg, prev, prev, imm_val));
            prev = dest_reg;
        end
        wait_drain();

        test_name = "mul_mix";
        for (int round = 0; round < 3; round++) begin
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(OP_ADDI, 1, 0, 0, imm_val));
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(OP_ADDI, 2, 0, 0, imm_val));
            send_instr(make_instr(OP_MUL, 3, 1, 2, 0));
            send_instr(make_instr(OP_ADD, 4, 1, 2, 0)); // finishes before the multiply
            send_instr(make_instr(OP_XOR, 5, 1, 2, 0));
            send_instr(make_instr(OP_MUL, 6, 2, 1, 0));
            send_instr(make_instr(OP_SUB, 7, 1, 2, 0));
        end
        wait_drain();

        test_name = "random_backpressure";
        random_stall <= 1'b1;
        for (int n = 0; n < 160; n++) begin
            op = opcode_t'($urandom_range(0, 5));
            dest_reg = $urandom_range(0, 15);
            src_a = $urandom_range(0, 15);
            src_b = $urandom_range(0, 15);
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(op, dest_reg, src_a, src_b, imm_val));
        end
        wait_drain();
        random_stall <= 1'b0;
        check_value("commit count", accept_count, commit_count);

        test_name = "repeated_writes";
        for (int k = 0; k < 4; k++) begin
            imm_val = $urandom_range(0, 65535);
            send_instr(make_instr(OP_ADDI, 9, 0, 0, imm_val));
        end
        imm_val = $urandom_range(0, 65535);
        send_instr(make_instr(OP_ADDI, 9, 9, 0, imm_val));
        send_instr(make_instr(OP_ADD, 10, 9, 9, 0));
        send_instr(make_instr(OP_XOR, 11, 9, 10, 0));
        wait_drain();
        check_value("commit count", accept_count, commit_count);

        $display("errors: %0d, accepted: %0d, committed: %0d",
                 error_count, accept_count, commit_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ooo_core.f
+incdir+include
source/ooo_core_pkg.sv
source/regfile.sv
source/dispatch_stage.sv
source/execute_stage.sv
source/reorder_buffer.sv
source/ooo_core_top.sv
tb/tb_ooo_core.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_ooo_core with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f ooo_core.f -o sim_ooo_core
	@out="$$(./obj_dir/sim_ooo_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
